/* tests/spectrum_trace.txt */
# M model | T turbo | O io_addr data | I io_addr exp_data | P rom_addr data (dropped write)
# W addr data exp_byte_addr | R addr exp_byte_addr exp_data   (all fields hex)
M 1
W 4001 a5 014001
R 4001 014001 a5
W 8002 3c 008002
W c003 77 000003
R 0010 140010 04
P 0020 99
R 0020 140020 34
O 7ffd 03
W c004 e1 00c004
O 7ffd 17
W c006 42 01c006
R 0001 144001 55
O 7ffd 20
O 7ffd 07
R c003 000003 77
R 0001 140001 15
I 00fe ff
M 0
O 7ffd 05
R c003 000003 77
R 0002 140002 16
T 4
W 8010 c1 008010
T 0
R 4001 014001 a5
M 2
T 2
O 3ffd 03
R c003 000003 77
O 7ffd 12
O 1ffd 04
R 0003 14c003 d7
R c010 008010 c1
T 1
O 1ffd 01
W 0005 11 000005
R c004 00c004 e1
O 1ffd 03
W 0006 22 010006
O 1ffd 05
R 0006 010006 22
R c004 00c004 e1
T 3
O 1ffd 07
R 4006 01c006 42
R 8005 018005 84

/* files.f */
common/spectrum_pkg.sv
hdl/ce_gen.sv
hdl/bus_sequencer.sv
paging/page_regs.sv
paging/addr_map.sv
hdl/mem_port.sv
hdl/spectrum_mem.sv
tests/tb_spectrum_mem.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_spectrum_mem -f files.f \
	-Mdir obj_dir -o sim_spectrum_mem \
	&& ./obj_dir/sim_spectrum_mem | tee /dev/stderr | grep -x "Test completed successfully" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* tests/tb_spectrum_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_spectrum_mem;

	localparam int TIMEOUT = 200;   // Cycles allowed for any single wait

	logic                                    clk_sys = 1'b0;
	logic                                    reset;
	spectrum_pkg::model_t                    model;
	logic [spectrum_pkg::TURBO_W-1:0]        turbo;
	logic                                    bus_valid;
	logic                                    bus_write;
	logic                                    bus_io;
	logic [15:0]                             bus_addr;
	logic [7:0]                              bus_wdata;
	logic                                    bus_ready;
	logic                                    rsp_valid;
	logic [7:0]                              rsp_data;
	logic                                    mem_valid;
	logic                                    mem_we;
	logic [spectrum_pkg::SDRAM_AW-2:0]       mem_addr;
	logic [1:0]                              mem_ds;
	logic [15:0]                             mem_wdata;
	logic                                    mem_ready = 1'b0;
	logic                                    mem_rvalid = 1'b0;
	logic [15:0]                             mem_rdata = 16'h0000;

	// Memory model state
	logic [7:0]  mem_bytes [logic [23:0]];
	int          seed = 53710;
	int          rd_wait = 0;
	logic [15:0] rd_word;
	logic        held = 1'b0;
	logic [42:0] held_req;
	int          hs_count = 0;
	logic        hs_we;
	logic [22:0] hs_addr;
	logic [1:0]  hs_ds;
	logic [15:0] hs_wdata;

	// Run bookkeeping
	int          err_count = 0;
	int          check_count = 0;
	logic        timed_out = 1'b0;

	spectrum_mem i_spectrum_mem (
		.clk_sys, .reset, .model, .turbo,
		.bus_valid, .bus_write, .bus_io, .bus_addr, .bus_wdata,
		.bus_ready, .rsp_valid, .rsp_data,
		.mem_valid, .mem_we, .mem_addr, .mem_ds, .mem_wdata,
		.mem_ready, .mem_rvalid, .mem_rdata
	);

	always #2 clk_sys = ~clk_sys;

	task automatic check(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		check_count++;
		if (expected !== actual) begin
			err_count++;
			$display("FAIL %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	// Unwritten SDRAM bytes read back as a hash of their address
	function automatic logic [7:0] read_byte(input logic [23:0] a);
		if (mem_bytes.exists(a))
			return mem_bytes[a];
		return a[7:0] ^ a[15:8] ^ a[23:16];
	endfunction

	// ====================================================================
	// SDRAM model acting on the falling edge
	// ====================================================================
	always @(negedge clk_sys) begin
		if (held)   // Request must not move after a stall
			check("mem request held", 64'(held_req),
				64'({mem_valid, mem_we, mem_ds, mem_addr, mem_wdata}));
		if (mem_rvalid) begin
			mem_rvalid = 1'b0;
		end else if (rd_wait > 0) begin
			rd_wait = rd_wait - 1;
			if (rd_wait == 0) begin
				mem_rvalid = 1'b1;
				mem_rdata  = rd_word;
			end
		end
		mem_ready = (($random(seed) & 3) != 0);   // Stall about one cycle in four
		held      = mem_valid && !mem_ready;
		held_req  = {mem_valid, mem_we, mem_ds, mem_addr, mem_wdata};
		if (mem_valid && mem_ready) begin   // Handshake on the coming rising edge
			hs_count++;
			hs_we    = mem_we;
			hs_addr  = mem_addr;
			hs_ds    = mem_ds;
			hs_wdata = mem_wdata;
			if (mem_we) begin
				if (mem_ds[1])
					mem_bytes[{mem_addr, 1'b1}] = mem_wdata[15:8];
				if (mem_ds[0])
					mem_bytes[{mem_addr, 1'b0}] = mem_wdata[7:0];
			end else begin
				rd_word = {read_byte({mem_addr, 1'b1}), read_byte({mem_addr, 1'b0})};
				rd_wait = 1 + ($unsigned($random(seed)) % 4);
			end
		end
	end

	task automatic apply_reset(input spectrum_pkg::model_t m);
		model = m;
		reset = 1'b1;
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	// One CPU access that starts and ends on a falling edge
	task automatic bus_access(input logic wr, input logic io, input logic [15:0] addr,
			input logic [7:0] wdata, output logic [7:0] rdata);
		int cycles;
		rdata     = 8'h00;
		bus_valid = 1'b1;
		bus_write = wr;
		bus_io    = io;
		bus_addr  = addr;
		bus_wdata = wdata;
		cycles    = 0;
		while (!bus_ready && cycles < TIMEOUT) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (!bus_ready) begin
			$display("Timeout: bus_ready never rose for address %h", addr);
			timed_out = 1'b1;
		end
		@(negedge clk_sys);   // Request taken at the edge just passed
		bus_valid = 1'b0;
		if (!timed_out) begin
			cycles = 0;
			while (!rsp_valid && cycles < TIMEOUT) begin
				@(negedge clk_sys);
				cycles++;
			end
			if (rsp_valid) begin
				rdata = rsp_data;
			end else begin
				$display("Timeout: no response for address %h", addr);
				timed_out = 1'b1;
			end
		end
	endtask

	// ====================================================================
	// Trace player
	// ====================================================================
	initial begin
		int          fd;
		int          n;
		int          fields;
		int          ch;
		int          test_no;
		int          errs_before;
		int          hs_before;
		logic [7:0]  op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [7:0]  rdata;
		string       name;

		reset     = 1'b1;
		model     = spectrum_pkg::MODEL_128;
		turbo     = spectrum_pkg::TURBO_3M5;
		bus_valid = 1'b0;
		bus_write = 1'b0;
		bus_io    = 1'b0;
		bus_addr  = 16'h0000;
		bus_wdata = 8'h00;
		test_no   = 0;
		@(negedge clk_sys);

		fd = $fopen("tests/spectrum_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file tests/spectrum_trace.txt");
			err_count++;
		end
		while (fd != 0 && !timed_out && $fscanf(fd, " %c", op) == 1) begin
			if (op == "#") begin   // Comment line
				ch = $fgetc(fd);
				while (ch != 10 && ch != -1)
					ch = $fgetc(fd);
				continue;
			end
			case (op)
				"M", "T":      fields = 1;
				"O", "I", "P": fields = 2;
				default:       fields = 3;
			endcase
			case (fields)
				1:       n = $fscanf(fd, "%h", a);
				2:       n = $fscanf(fd, "%h %h", a, b);
				default: n = $fscanf(fd, "%h %h %h", a, b, c);
			endcase
			test_no++;
			name        = $sformatf("test %0d %c %h", test_no, op, a[15:0]);
			errs_before = err_count;
			hs_before   = hs_count;
			if (n != fields) begin
				$display("Trace line of %s has %0d fields where %0d belong", name, n, fields);
				err_count++;
			end
			case (op)
				"M": apply_reset(a[1:0]);
				"T": turbo = a[spectrum_pkg::TURBO_W-1:0];   // Settle is covered by the bus_ready wait
				"O", "I", "P": begin   // No SDRAM traffic expected
					bus_access(op != "I", op != "P", a[15:0], b[7:0], rdata);
					check({name, " handshakes"}, 64'(hs_before), 64'(hs_count));
					check({name, " data"}, (op == "I") ? 64'(b[7:0]) : 64'h0, 64'(rdata));
				end
				"W": begin
					bus_access(1'b1, 1'b0, a[15:0], b[7:0], rdata);
					check({name, " handshakes"}, 64'(hs_before + 1), 64'(hs_count));
					check({name, " addr"}, 64'(c[23:0]), 64'({hs_addr, hs_ds == 2'b10}));
					check({name, " lanes"}, c[0] ? 64'h2 : 64'h1, 64'(hs_ds));
					check({name, " wdata"}, 64'({b[7:0], b[7:0]}), 64'(hs_wdata));
					check({name, " we"}, 64'h1, 64'(hs_we));
					check({name, " data"}, 64'h0, 64'(rdata));
				end
				"R": begin
					bus_access(1'b0, 1'b0, a[15:0], 8'h00, rdata);
					check({name, " handshakes"}, 64'(hs_before + 1), 64'(hs_count));
					check({name, " addr"}, 64'(b[23:1]), 64'(hs_addr));
					check({name, " lanes"}, 64'h3, 64'(hs_ds));
					check({name, " we"}, 64'h0, 64'(hs_we));
					check({name, " data"}, 64'(c[7:0]), 64'(rdata));
				end
				default: begin
					$display("Unknown trace operation %c in %s", op, name);
					err_count++;
				end
			endcase
			$display("%s : %s", name,
				(err_count == errs_before && !timed_out) ? "ok" : "errors");
		end

		$display("Tests run %0d, checks %0d, errors %0d", test_no, check_count, err_count);
		if (err_count == 0 && !timed_out && test_no > 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/spectrum_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module spectrum_mem (
	input  wire logic                                clk_sys,
	input  wire logic                                reset,
	input  wire spectrum_pkg::model_t                model,
	input  wire logic [spectrum_pkg::TURBO_W-1:0]    turbo,

	// CPU bus
	input  wire logic                                bus_valid,
	input  wire logic                                bus_write,
	input  wire logic                                bus_io,
	input  wire logic [15:0]                         bus_addr,
	input  wire logic [7:0]                          bus_wdata,
	output logic                                     bus_ready,
	output logic                                     rsp_valid,
	output logic [7:0]                               rsp_data,

	// SDRAM port
	output logic                                     mem_valid,
	output logic                                     mem_we,
	output logic [spectrum_pkg::SDRAM_AW-2:0]        mem_addr,
	output logic [1:0]                               mem_ds,
	output logic [15:0]                              mem_wdata,
	input  wire logic                                mem_ready,
	input  wire logic                                mem_rvalid,
	input  wire logic [15:0]                         mem_rdata
);

	logic                               ce_cpu;
	logic                               io_wr_stb;
	logic [15:0]                        req_addr;
	logic [7:0]                         req_wdata;
	logic                               req_write;
	logic                               mem_start;
	logic                               mem_done;
	logic [7:0]                         mem_rbyte;
	logic                               rom_window;
	logic [spectrum_pkg::SDRAM_AW-1:0]  byte_addr;
	spectrum_pkg::model_t               cur_model;
	logic [7:0]                         page_7ffd;
	logic [7:0]                         page_1ffd;

	ce_gen i_ce_gen (
		.clk_sys, .reset, .turbo, .ce_cpu
	);

	bus_sequencer i_bus_sequencer (
		.clk_sys, .reset, .ce_cpu,
		.bus_valid, .bus_write, .bus_io, .bus_addr, .bus_wdata,
		.bus_ready, .rsp_valid, .rsp_data,
		.rom_window, .mem_done, .mem_rbyte,
		.io_wr_stb, .req_addr, .req_wdata, .req_write, .mem_start
	);

	page_regs i_page_regs (
		.clk_sys, .reset, .model,
		.io_wr_stb, .req_addr, .req_wdata,
		.cur_model, .page_7ffd, .page_1ffd
	);

	addr_map i_addr_map (
		.cur_model, .page_7ffd, .page_1ffd, .req_addr,
		.byte_addr, .rom_window
	);

	mem_port i_mem_port (
		.clk_sys, .reset,
		.mem_start, .req_write, .req_wdata, .byte_addr,
		.mem_valid, .mem_we, .mem_addr, .mem_ds, .mem_wdata,
		.mem_ready, .mem_rvalid, .mem_rdata,
		.mem_done, .mem_rbyte
	);

endmodule

`default_nettype wire

/* hdl/mem_port.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_port (
	input  wire logic                                clk_sys,
	input  wire logic                                reset,

	input  wire logic                                mem_start,
	input  wire logic                                req_write,
	input  wire logic [7:0]                          req_wdata,
	input  wire logic [spectrum_pkg::SDRAM_AW-1:0]   byte_addr,

	// 16-bit SDRAM port
	output logic                                     mem_valid,
	output logic                                     mem_we,
	output logic [spectrum_pkg::SDRAM_AW-2:0]        mem_addr,
	output logic [1:0]                               mem_ds,
	output logic [15:0]                              mem_wdata,
	input  wire logic                                mem_ready,
	input  wire logic                                mem_rvalid,
	input  wire logic [15:0]                         mem_rdata,

	output logic                                     mem_done,
	output logic [7:0]                               mem_rbyte
);

	logic rd_pending;
	logic lane_q;   // Byte address bit 0
	logic hs;

	assign hs = mem_valid && mem_ready;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mem_valid  <= 1'b0;
			rd_pending <= 1'b0;
		end else begin
			if (mem_start)
				mem_valid <= 1'b1;
			else if (hs)
				mem_valid <= 1'b0;

			if (hs && !mem_we)
				rd_pending <= 1'b1;
			else if (mem_rvalid)
				rd_pending <= 1'b0;
		end
	end

	// Held stable until the handshake
	always_ff @(posedge clk_sys) begin
		if (mem_start) begin
			mem_we    <= req_write;
			mem_addr  <= byte_addr[spectrum_pkg::SDRAM_AW-1:1];
			lane_q    <= byte_addr[0];
			mem_ds    <= req_write ? {byte_addr[0], ~byte_addr[0]} : 2'b11;   // Reads fetch both lanes
			mem_wdata <= {req_wdata, req_wdata};
		end
	end

	assign mem_done  = (hs && mem_we) || (rd_pending && mem_rvalid);
	assign mem_rbyte = lane_q ? mem_rdata[15:8] : mem_rdata[7:0];

endmodule

`default_nettype wire

/* paging/addr_map.sv */
`timescale 1ns/1ns
`default_nettype none

module addr_map (
	input  wire spectrum_pkg::model_t              cur_model,
	input  wire logic [7:0]                        page_7ffd,
	input  wire logic [7:0]                        page_1ffd,
	input  wire logic [15:0]                       req_addr,
	output logic [spectrum_pkg::SDRAM_AW-1:0]      byte_addr,
	output logic                                   rom_window
);

	logic [1:0]                              win;
	logic [spectrum_pkg::PAGE_OFS_W-1:0]     ofs;
	logic                                    special;
	logic [spectrum_pkg::ROM_PAGE_W-1:0]     rom_page;
	logic [spectrum_pkg::BANK_W-1:0]         bank;
	logic [spectrum_pkg::SDRAM_AW-1:0]       rom_ofs;
	logic [spectrum_pkg::SDRAM_AW-1:0]       ram_ofs;

	assign win     = req_addr[15:14];
	assign ofs     = req_addr[13:0];
	assign special = (cur_model == spectrum_pkg::MODEL_PLUS3) && page_1ffd[0];   // +3 all-RAM

	always_comb begin
		case (cur_model)
			spectrum_pkg::MODEL_48:    rom_page = 2'd0;
			spectrum_pkg::MODEL_PLUS3: rom_page = {page_1ffd[2], page_7ffd[4]};
			default:                   rom_page = {1'b0, page_7ffd[4]};
		endcase

		if (special) begin
			case (page_1ffd[2:1])
				2'b00: bank = {1'b0, win};   // 0 1 2 3
				2'b01: bank = {1'b1, win};   // 4 5 6 7
				2'b10: bank = (win == 2'd3) ? 3'd3 : {1'b1, win};   // 4 5 6 3
				default: begin   // 4 7 6 3
					case (win)
						2'd0:    bank = 3'd4;
						2'd1:    bank = 3'd7;
						2'd2:    bank = 3'd6;
						default: bank = 3'd3;
					endcase
				end
			endcase
		end else begin
			case (win)
				2'd1:    bank = 3'd5;
				2'd2:    bank = 3'd2;
				2'd3:    bank = (cur_model == spectrum_pkg::MODEL_48) ? 3'd0 : page_7ffd[2:0];
				default: bank = 3'd0;   // ROM window, bank unused
			endcase
		end

		rom_ofs = '0;
		rom_ofs[spectrum_pkg::ROM_PAGE_W+spectrum_pkg::PAGE_OFS_W-1:0] = {rom_page, ofs};
		ram_ofs = '0;
		ram_ofs[spectrum_pkg::BANK_W+spectrum_pkg::PAGE_OFS_W-1:0] = {bank, ofs};
	end

	assign rom_window = !special && (win == 2'd0);
	assign byte_addr  = rom_window ? spectrum_pkg::ROM_BASE + rom_ofs
	                               : spectrum_pkg::RAM_BASE + ram_ofs;

endmodule

`default_nettype wire

/* paging/page_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module page_regs (
	input  wire logic                 clk_sys,
	input  wire logic                 reset,
	input  wire spectrum_pkg::model_t model,

	input  wire logic                 io_wr_stb,
	input  wire logic [15:0]          req_addr,
	input  wire logic [7:0]           req_wdata,

	output spectrum_pkg::model_t      cur_model,
	output logic [7:0]                page_7ffd,
	output logic [7:0]                page_1ffd
);

	logic is_48;
	logic is_plus3;
	logic sel_7ffd;
	logic sel_1ffd;
	logic locked;
	spectrum_pkg::model_t model_norm;

	// Code 3 has no machine of its own
	always_comb begin
		if (model == spectrum_pkg::MODEL_48 || model == spectrum_pkg::MODEL_PLUS3)
			model_norm = model;
		else
			model_norm = spectrum_pkg::MODEL_128;
	end

	assign is_48    = (cur_model == spectrum_pkg::MODEL_48);
	assign is_plus3 = (cur_model == spectrum_pkg::MODEL_PLUS3);

	// ====================================================================
	// Port decode
	// ====================================================================
	// 7FFD, partial decode; the +3 also looks at A14
	assign sel_7ffd = !req_addr[15] && !req_addr[1] && (req_addr[14] || !is_plus3);

	// 1FFD exists on the +3 only
	assign sel_1ffd = is_plus3 && (req_addr[15:12] == 4'b0001) && !req_addr[1];

	// 7FFD bit 5 freezes both ports until reset
	assign locked = is_48 || page_7ffd[5];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cur_model <= model_norm;   // Model follows the input throughout reset
			page_7ffd <= 8'h00;
			page_1ffd <= 8'h00;
		end else if (io_wr_stb && !locked) begin
			if (sel_7ffd)
				page_7ffd <= req_wdata;
			if (sel_1ffd)
				page_1ffd <= req_wdata;
		end
	end

endmodule

`default_nettype wire

/* hdl/bus_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_sequencer (
	input  wire logic        clk_sys,
	input  wire logic        reset,
	input  wire logic        ce_cpu,

	// CPU bus
	input  wire logic        bus_valid,
	input  wire logic        bus_write,
	input  wire logic        bus_io,
	input  wire logic [15:0] bus_addr,
	input  wire logic [7:0]  bus_wdata,
	output logic             bus_ready,
	output logic             rsp_valid,
	output logic [7:0]       rsp_data,

	// Paging and memory side
	input  wire logic        rom_window,
	input  wire logic        mem_done,
	input  wire logic [7:0]  mem_rbyte,
	output logic             io_wr_stb,
	output logic [15:0]      req_addr,
	output logic [7:0]       req_wdata,
	output logic             req_write,
	output logic             mem_start
);

	spectrum_pkg::seq_state_t state;

	logic        accept;
	logic        mem_path;
	logic        idle;
	logic [15:0] addr_q;
	logic [7:0]  wdata_q;
	logic        write_q;

	assign idle      = (state == spectrum_pkg::IDLE);
	assign bus_ready = idle && ce_cpu;
	assign accept    = bus_valid && bus_ready;
	assign rsp_valid = (state == spectrum_pkg::RESP);

	// While idle the live bus request feeds the address map, so the
	// ROM-window check and the memory issue both happen at acceptance
	assign req_addr  = idle ? bus_addr  : addr_q;
	assign req_wdata = idle ? bus_wdata : wdata_q;
	assign req_write = idle ? bus_write : write_q;

	// Writes into the ROM window never reach SDRAM
	assign mem_path  = !bus_io && !(bus_write && rom_window);
	assign mem_start = accept && mem_path;

	// ====================================================================
	// Control
	// ====================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state     <= spectrum_pkg::IDLE;
			io_wr_stb <= 1'b0;
		end else begin
			io_wr_stb <= accept && bus_io && bus_write;   // Paging port write

			case (state)
				spectrum_pkg::IDLE: begin
					if (accept) begin
						if (!mem_path)
							state <= spectrum_pkg::RESP;
						else if (bus_write)
							state <= spectrum_pkg::MEM_REQ;
						else
							state <= spectrum_pkg::MEM_WAIT;
					end
				end
				spectrum_pkg::MEM_REQ,
				spectrum_pkg::MEM_WAIT: begin
					if (mem_done)
						state <= spectrum_pkg::RESP;
				end
				default: state <= spectrum_pkg::IDLE;   // RESP lasts one cycle
			endcase
		end
	end

	// ====================================================================
	// Request and response registers
	// ====================================================================
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			addr_q   <= bus_addr;
			wdata_q  <= bus_wdata;
			write_q  <= bus_write;
			// IO reads float high, writes answer zero
			rsp_data <= (bus_io && !bus_write) ? 8'hFF : 8'h00;
		end
		if ((state == spectrum_pkg::MEM_WAIT) && mem_done)
			rsp_data <= mem_rbyte;
	end

endmodule

`default_nettype wire

/* hdl/ce_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module ce_gen (
	input  wire logic                            clk_sys,
	input  wire logic                            reset,
	input  wire logic [spectrum_pkg::TURBO_W-1:0] turbo,
	output logic                                 ce_cpu
);

	logic [spectrum_pkg::TURBO_W-1:0] turbo_q;
	logic [3:0] cnt;
	logic [3:0] mask;
	logic [2:0] settle;

	// Counter bits that must be zero for a CPU cycle
	always_comb begin
		case (turbo_q)
			spectrum_pkg::TURBO_3M5: mask = 4'b1111;
			spectrum_pkg::TURBO_7M:  mask = 4'b0111;
			spectrum_pkg::TURBO_14M: mask = 4'b0011;
			spectrum_pkg::TURBO_28M: mask = 4'b0001;
			spectrum_pkg::TURBO_56M: mask = 4'b0000;
			default:                 mask = 4'b0011;   // Unused codes run at /4
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			turbo_q <= turbo;
			settle  <= 3'd0;
			cnt     <= 4'd0;
			ce_cpu  <= 1'b0;
		end else if (turbo != turbo_q) begin
			turbo_q <= turbo;   // Speed change, stop the CPU for a moment
			settle  <= spectrum_pkg::TURBO_SETTLE;
			cnt     <= 4'd0;
			ce_cpu  <= 1'b0;
		end else if (settle != 3'd0) begin
			settle <= settle - 3'd1;
			cnt    <= 4'd0;
			ce_cpu <= 1'b0;
		end else begin
			cnt    <= cnt + 4'd1;
			ce_cpu <= ((cnt & mask) == 4'd0);
		end
	end

endmodule

`default_nettype wire

/* common/spectrum_pkg.sv */
`default_nettype none

package spectrum_pkg;

	// ====================================================================
	// Machine model
	// ====================================================================
	typedef logic [1:0] model_t;

	localparam model_t MODEL_48    = 2'd0;
	localparam model_t MODEL_128   = 2'd1;   // Also stands in for code 3
	localparam model_t MODEL_PLUS3 = 2'd2;

	// ====================================================================
	// CPU speed
	// ====================================================================
	localparam int TURBO_W = 3;

	localparam logic [TURBO_W-1:0] TURBO_3M5 = 3'd0;   // clk_sys / 16
	localparam logic [TURBO_W-1:0] TURBO_7M  = 3'd1;   // clk_sys / 8
	localparam logic [TURBO_W-1:0] TURBO_14M = 3'd2;   // clk_sys / 4
	localparam logic [TURBO_W-1:0] TURBO_28M = 3'd3;   // clk_sys / 2
	localparam logic [TURBO_W-1:0] TURBO_56M = 3'd4;   // every clk_sys

	// CPU held off this long after a speed change
	localparam logic [2:0] TURBO_SETTLE = 3'd4;

	// ====================================================================
	// Memory layout
	// ====================================================================
	localparam int BANK_W     = 3;    // 16K RAM bank number
	localparam int ROM_PAGE_W = 2;
	localparam int PAGE_OFS_W = 14;   // Offset inside a 16K page
	localparam int SDRAM_AW   = 24;   // Byte address

	localparam logic [SDRAM_AW-1:0] RAM_BASE = 24'h000000;
	localparam logic [SDRAM_AW-1:0] ROM_BASE = 24'h140000;

	// Bus sequencer
	typedef enum logic [1:0] {
		IDLE,
		MEM_REQ,    // Memory write waiting for its handshake
		MEM_WAIT,   // Memory read waiting for data
		RESP
	} seq_state_t;

endpackage

`default_nettype wire
